//--- Bender.yml
package:
  name: yaw_tracker

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/angle_pkg.sv
      - common/imu_pkg.sv
      - rtl/gyro_integrator.sv
      - yaw_normalizer/yaw_normalizer.sv
      - rtl/relative_yaw.sv
      - rtl/yaw_tracker_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - verification/yaw_tracker_tb.sv

//--- common/angle_macros.svh
`ifndef ANGLE_MACROS_SVH
`define ANGLE_MACROS_SVH

// Angle word layout, Q16.15 degrees
`define ANGLE_WIDTH      32
`define ANGLE_FRAC_BITS  15
// Signed whole-degree part of the angle word
`define ANGLE_INT_BITS   (`ANGLE_WIDTH - `ANGLE_FRAC_BITS)

// Gyro rate sample layout, Q8.7 degrees per sample
`define RATE_WIDTH       16
`define RATE_FRAC_BITS   7

// Left shift that moves a rate sample onto the angle grid
`define RATE_SHIFT       (`ANGLE_FRAC_BITS - `RATE_FRAC_BITS)

// 360 * 2^15
`define DEG_360          (32'sd11796480)
// 180 * 2^15
`define DEG_180          (32'sd5898240)

// Whole-degree heading, 0 to 359
`define HEADING_WIDTH    9
`define HEADING_MAX      359

`endif

//--- common/angle_pkg.sv
`default_nettype none

package angle_pkg;

`include "angle_macros.svh"

    // Signed Q16.15 angle in degrees
    // Raw integrator output is unwrapped, normalized values stay inside one turn
    typedef logic signed [`ANGLE_WIDTH-1:0] angle_t;

    // Field view of the same word
    // Upper bits carry signed whole degrees, lower bits the fraction
    typedef struct packed {
        logic signed [`ANGLE_INT_BITS-1:0]  int_deg;
        logic        [`ANGLE_FRAC_BITS-1:0] frac;
    } angle_fields_t;

    // One angle word, two readings
    // Arithmetic uses value, heading extraction uses fields
    typedef union packed {
        angle_t        value;
        angle_fields_t fields;
    } angle_word_u;

    // Whole degrees of a normalized heading
    typedef logic [`HEADING_WIDTH-1:0] heading_t;

endpackage

`default_nettype wire

//--- common/imu_pkg.sv
`default_nettype none

package imu_pkg;

`include "angle_macros.svh"

    // Yaw-rate sample from one gyro
    // Signed Q8.7, degrees per sample strobe
    // Range is roughly -256 to +256 degrees per sample
    typedef logic signed [`RATE_WIDTH-1:0] rate_t;

endpackage

`default_nettype wire

//--- rtl/gyro_integrator.sv
`timescale 1ns/1ps
`default_nettype none

`include "angle_macros.svh"

module gyro_integrator (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              sample_valid,
    input  imu_pkg::rate_t    rate,
    output angle_pkg::angle_t raw_yaw,
    output logic              raw_valid
);

    // Rate moved onto the Q16.15 angle grid
    angle_pkg::angle_t rate_scaled;
    // Running yaw, deliberately never wrapped
    angle_pkg::angle_t acc_q;
    angle_pkg::angle_t acc_next;

    // Widen with sign first, then shift up by the fraction difference
    assign rate_scaled = angle_pkg::angle_t'(rate) <<< `RATE_SHIFT;

    assign acc_next = acc_q + rate_scaled;

    // Accumulate only on a sample strobe
    // Value holds between strobes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q <= '0;
        end else if (sample_valid) begin
            acc_q <= acc_next;
        end
    end

    // Valid is the strobe delayed by one clock
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            raw_valid <= 1'b0;
        end else begin
            raw_valid <= sample_valid;
        end
    end

    assign raw_yaw = acc_q;

    // Signed overflow of the running sum
    // Operands agree in sign but the sum flips, the turn count is lost
    acc_no_overflow_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        sample_valid |->
            !((acc_q[`ANGLE_WIDTH-1] == rate_scaled[`ANGLE_WIDTH-1]) &&
              (acc_next[`ANGLE_WIDTH-1] != acc_q[`ANGLE_WIDTH-1]))
    );

endmodule

`default_nettype wire

//--- rtl/relative_yaw.sv
`timescale 1ns/1ps
`default_nettype none

`include "angle_macros.svh"

module relative_yaw (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                norm_valid,
    input  angle_pkg::angle_t   yaw_a,
    input  angle_pkg::angle_t   yaw_b,
    output angle_pkg::angle_t   rel_yaw,
    output angle_pkg::heading_t heading,
    output logic                out_valid
);

    // Both inputs lie in 0 to 360, so the raw difference is within one turn
    angle_pkg::angle_t   diff;
    angle_pkg::angle_t   rel_next;

    // Channel A seen through its field view
    angle_pkg::angle_word_u a_word;
    angle_pkg::heading_t    heading_next;

    assign diff = yaw_a - yaw_b;

    // Fold into -180 to below +180
    always_comb begin
        if (diff >= `DEG_180) begin
            rel_next = diff - `DEG_360;
        end else if (diff < -`DEG_180) begin
            rel_next = diff + `DEG_360;
        end else begin
            rel_next = diff;
        end
    end

    // Whole degrees, fraction dropped by truncation
    // yaw_a is never negative here, so the low bits of int_deg are the heading
    assign a_word.value  = yaw_a;
    assign heading_next = a_word.fields.int_deg[`HEADING_WIDTH-1:0];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rel_yaw   <= '0;
            heading   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= norm_valid;
            if (norm_valid) begin
                rel_yaw <= rel_next;
                heading <= heading_next;
            end
        end
    end

    rel_range_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (rel_yaw >= -`DEG_180) && (rel_yaw < `DEG_180)
    );

    heading_range_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        out_valid |-> (heading <= `HEADING_MAX)
    );

endmodule

`default_nettype wire

//--- rtl/yaw_tracker_top.sv
`timescale 1ns/1ps
`default_nettype none

module yaw_tracker_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                sample_valid,
    input  logic                calibrate,
    input  imu_pkg::rate_t      rate_a,
    input  imu_pkg::rate_t      rate_b,
    output angle_pkg::angle_t   yaw_a,
    output angle_pkg::angle_t   yaw_b,
    output angle_pkg::angle_t   rel_yaw,
    output angle_pkg::heading_t heading,
    output logic                out_valid
);

    // calibrate is only meaningful with a strobe, aligned here to raw_valid
    logic              calibrate_q;

    angle_pkg::angle_t raw_yaw_a;
    angle_pkg::angle_t raw_yaw_b;
    logic              raw_valid_a;
    logic              raw_valid_b;

    angle_pkg::angle_t norm_yaw_a;
    angle_pkg::angle_t norm_yaw_b;
    logic              norm_valid_a;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            calibrate_q <= 1'b0;
        end else begin
            calibrate_q <= sample_valid && calibrate;
        end
    end

    // Channel A
    gyro_integrator gyro_integrator_a_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .rate         (rate_a),
        .raw_yaw      (raw_yaw_a),
        .raw_valid    (raw_valid_a)
    );

    yaw_normalizer yaw_normalizer_a_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .raw_valid  (raw_valid_a),
        .raw_yaw    (raw_yaw_a),
        .calibrate  (calibrate_q),
        .norm_yaw   (norm_yaw_a),
        .norm_valid (norm_valid_a)
    );

    // Channel B
    gyro_integrator gyro_integrator_b_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .rate         (rate_b),
        .raw_yaw      (raw_yaw_b),
        .raw_valid    (raw_valid_b)
    );

    // Same strobe as channel A, so its valid is a copy and stays open
    yaw_normalizer yaw_normalizer_b_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .raw_valid  (raw_valid_b),
        .raw_yaw    (raw_yaw_b),
        .calibrate  (calibrate_q),
        .norm_yaw   (norm_yaw_b),
        .norm_valid ()
    );

    // Relative stage runs off channel A's valid only
    relative_yaw relative_yaw_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .norm_valid (norm_valid_a),
        .yaw_a      (norm_yaw_a),
        .yaw_b      (norm_yaw_b),
        .rel_yaw    (rel_yaw),
        .heading    (heading),
        .out_valid  (out_valid)
    );

    // One register per channel so the yaws line up with out_valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            yaw_a <= '0;
            yaw_b <= '0;
        end else if (norm_valid_a) begin
            yaw_a <= norm_yaw_a;
            yaw_b <= norm_yaw_b;
        end
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+common
common/angle_pkg.sv
common/imu_pkg.sv
rtl/gyro_integrator.sv
yaw_normalizer/yaw_normalizer.sv
rtl/relative_yaw.sv
rtl/yaw_tracker_top.sv
verification/yaw_tracker_tb.sv

//--- verification/yaw_tracker_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "angle_macros.svh"

module yaw_tracker_tb;

    localparam int NUM_SAMPLES = 600;
    localparam int SEGMENT_LEN = 100;
    // 20 degrees per sample in Q8.7
    localparam int RATE_LIMIT  = 20 * 128;
    localparam int RATE_SCALE  = 1 << (`ANGLE_FRAC_BITS - `RATE_FRAC_BITS);
    localparam int DRAIN_LIMIT = 20;

    logic                clk;
    logic                rst_n;
    logic                sample_valid;
    logic                calibrate;
    imu_pkg::rate_t      rate_a;
    imu_pkg::rate_t      rate_b;
    angle_pkg::angle_t   yaw_a;
    angle_pkg::angle_t   yaw_b;
    angle_pkg::angle_t   rel_yaw;
    angle_pkg::heading_t heading;
    logic                out_valid;

    // Reference model, wide enough that it never wraps
    longint model_acc_a;
    longint model_acc_b;
    longint model_off_a;
    longint model_off_b;
    angle_pkg::angle_t   exp_yaw_a[$];
    angle_pkg::angle_t   exp_yaw_b[$];
    angle_pkg::angle_t   exp_rel[$];
    angle_pkg::heading_t exp_heading[$];

    // Outputs seen at the previous falling edge
    angle_pkg::angle_t   last_yaw_a;
    angle_pkg::angle_t   last_yaw_b;
    angle_pkg::angle_t   last_rel;
    angle_pkg::heading_t last_heading;
    // Strobe history, bit 3 is the strobe four clocks back
    logic [3:0]          valid_hist;

    logic [31:0] rng_state;
    int          value_errors;
    int          timing_errors;
    int          timeout_errors;

    yaw_tracker_top yaw_tracker_top_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .sample_valid (sample_valid),
        .calibrate    (calibrate),
        .rate_a       (rate_a),
        .rate_b       (rate_b),
        .yaw_a        (yaw_a),
        .yaw_b        (yaw_b),
        .rel_yaw      (rel_yaw),
        .heading      (heading),
        .out_valid    (out_valid)
    );

    always #50 clk = ~clk;

    function automatic int random_below(input int range);
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return int'(rng_state % range);
    endfunction

    // Mode 0 turns right, mode 1 turns left, otherwise either way
    function automatic int random_rate(input int mode);
        if (mode == 0) begin
            return random_below(RATE_LIMIT + 1);
        end else if (mode == 1) begin
            return -random_below(RATE_LIMIT + 1);
        end
        return random_below(2 * RATE_LIMIT + 1) - RATE_LIMIT;
    endfunction

    // Into 0 to below 360 by whole turns
    function automatic angle_pkg::angle_t fold_turn(input longint v);
        longint t;
        t = v;
        while (t < 0) begin
            t += `DEG_360;
        end
        while (t >= `DEG_360) begin
            t -= `DEG_360;
        end
        return angle_pkg::angle_t'(t);
    endfunction

    // Into -180 to below 180
    function automatic angle_pkg::angle_t fold_half_turn(input longint d);
        if (d >= `DEG_180) begin
            return angle_pkg::angle_t'(d - `DEG_360);
        end else if (d < -`DEG_180) begin
            return angle_pkg::angle_t'(d + `DEG_360);
        end
        return angle_pkg::angle_t'(d);
    endfunction

    task automatic compare_value(input string name, input longint expected,
                                 input longint actual);
        assert (expected == actual) else begin
            $display("Error at %0t: %s expected %0d got %0d", $time, name, expected, actual);
            value_errors++;
        end
    endtask

    // Calibrating sample leaves acc equal to offset, so its result folds to 0
    task automatic update_model();
        angle_pkg::angle_t ya;
        angle_pkg::angle_t yb;
        model_acc_a += longint'(rate_a) * RATE_SCALE;
        model_acc_b += longint'(rate_b) * RATE_SCALE;
        if (calibrate) begin
            model_off_a = model_acc_a;
            model_off_b = model_acc_b;
        end
        ya = fold_turn(model_acc_a - model_off_a);
        yb = fold_turn(model_acc_b - model_off_b);
        exp_yaw_a.push_back(ya);
        exp_yaw_b.push_back(yb);
        exp_rel.push_back(fold_half_turn(longint'(ya) - longint'(yb)));
        // Truncated whole degrees, ya is never negative
        exp_heading.push_back(angle_pkg::heading_t'(ya / (1 << `ANGLE_FRAC_BITS)));
    endtask

    task automatic check_outputs();
        assert (out_valid == valid_hist[3]) else begin
            $display("Error at %0t: out_valid expected %0b got %0b",
                     $time, valid_hist[3], out_valid);
            timing_errors++;
        end
        if (out_valid) begin
            assert (exp_yaw_a.size() != 0) else begin
                $display("out_valid rose at %0t with no expected result queued", $time);
                timing_errors++;
            end
            if (exp_yaw_a.size() != 0) begin
                compare_value("yaw_a", exp_yaw_a.pop_front(), yaw_a);
                compare_value("yaw_b", exp_yaw_b.pop_front(), yaw_b);
                compare_value("rel_yaw", exp_rel.pop_front(), rel_yaw);
                compare_value("heading", exp_heading.pop_front(), heading);
            end
        end else begin
            // Outputs hold between results, and stay zero until the first one
            compare_value("held yaw_a", last_yaw_a, yaw_a);
            compare_value("held yaw_b", last_yaw_b, yaw_b);
            compare_value("held rel_yaw", last_rel, rel_yaw);
            compare_value("held heading", last_heading, heading);
        end
        last_yaw_a   = yaw_a;
        last_yaw_b   = yaw_b;
        last_rel     = rel_yaw;
        last_heading = heading;
    endtask

    // Falling edge sampling, inputs and outputs are settled here
    always @(negedge clk) begin
        if (rst_n) begin
            check_outputs();
            if (sample_valid) begin
                update_model();
            end
            valid_hist = {valid_hist[2:0], sample_valid};
        end
    end

    task automatic drive_sample(input int ra, input int rb, input logic cal);
        @(posedge clk);
        sample_valid <= 1'b1;
        rate_a       <= imu_pkg::rate_t'(ra);
        rate_b       <= imu_pkg::rate_t'(rb);
        calibrate    <= cal;
    endtask

    // Junk on rates and calibrate, ignored without a strobe
    task automatic drive_idle();
        @(posedge clk);
        sample_valid <= 1'b0;
        rate_a       <= imu_pkg::rate_t'(random_below(65536));
        rate_b       <= imu_pkg::rate_t'(random_below(65536));
        calibrate    <= (random_below(2) == 1);
    endtask

    task automatic wait_for_drain();
        int cycles;
        cycles = 0;
        while (exp_yaw_a.size() != 0 && cycles < DRAIN_LIMIT) begin
            drive_idle();
            cycles++;
        end
        assert (exp_yaw_a.size() == 0) else begin
            $display("Timed out after %0d cycles with %0d results still outstanding",
                     cycles, exp_yaw_a.size());
            timeout_errors++;
        end
    endtask

    initial begin
        int seg;
        clk = 1'b0;
        rst_n = 1'b0;
        sample_valid = 1'b0;
        calibrate = 1'b0;
        rate_a = '0;
        rate_b = '0;
        rng_state = 32'd46192;
        model_acc_a = 0;
        model_acc_b = 0;
        model_off_a = 0;
        model_off_b = 0;
        last_yaw_a = '0;
        last_yaw_b = '0;
        last_rel = '0;
        last_heading = '0;
        valid_hist = '0;
        value_errors = 0;
        timing_errors = 0;
        timeout_errors = 0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet stretch before the first strobe
        repeat (8) drive_idle();
        // Channels get biased segments so both wrap points are crossed both ways
        for (int i = 0; i < NUM_SAMPLES; i++) begin
            seg = i / SEGMENT_LEN;
            drive_sample(random_rate(seg % 3), random_rate((seg + 1) % 3),
                         random_below(40) == 0);
            if (random_below(3) == 0) begin
                repeat (1 + random_below(3)) drive_idle();
            end
        end
        // A at 90, B at 270, then one LSB either side of the -180 fold
        drive_sample(0, 0, 1'b1);
        drive_sample(90 * 128, -90 * 128, 1'b0);
        drive_sample(1, 0, 1'b0);
        drive_sample(-2, 0, 1'b0);
        drive_idle();
        // A at 270, B at 90, difference right at +180
        drive_sample(0, 0, 1'b1);
        drive_sample(-90 * 128, 90 * 128, 1'b0);
        drive_sample(1, 0, 1'b0);
        drive_sample(-2, 0, 1'b0);
        wait_for_drain();
        repeat (6) drive_idle();
        $display("Errors: value %0d, timing %0d, timeout %0d",
                 value_errors, timing_errors, timeout_errors);
        if (value_errors + timing_errors + timeout_errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- yaw_normalizer/yaw_normalizer.sv
`timescale 1ns/1ps
`default_nettype none

`include "angle_macros.svh"

module yaw_normalizer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              raw_valid,
    input  angle_pkg::angle_t raw_yaw,
    input  logic              calibrate,
    output angle_pkg::angle_t norm_yaw,
    output logic              norm_valid
);

    // Calibration offset, raw angle that maps to zero
    angle_pkg::angle_t offset_q;

    // Stage 1, offset removed but not yet folded
    angle_pkg::angle_t s1_diff;
    logic              s1_valid;

    // Stage 2 combinational fold
    angle_pkg::angle_t rem;
    angle_pkg::angle_t folded;

    // Capture the current raw angle on a calibrate sample
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            offset_q <= '0;
        end else if (raw_valid && calibrate) begin
            offset_q <= raw_yaw;
        end
    end

    // Stage 1
    // Calibrating sample sees the new offset already, so its result is exactly zero
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_diff  <= '0;
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= raw_valid;
            if (raw_valid) begin
                s1_diff <= calibrate ? '0 : (raw_yaw - offset_q);
            end
        end
    end

    // Signed remainder keeps the sign of the dividend
    // One correction step lifts a negative remainder into 0 to 360
    always_comb begin
        rem = s1_diff % `DEG_360;
        if (rem < 0) begin
            folded = rem + `DEG_360;
        end else begin
            folded = rem;
        end
    end

    // Stage 2
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            norm_yaw   <= '0;
            norm_valid <= 1'b0;
        end else begin
            norm_valid <= s1_valid;
            if (s1_valid) begin
                norm_yaw <= folded;
            end
        end
    end

    // Normalized output stays within one turn
    norm_range_a: assert property (
        @(posedge clk) disable iff (!rst_n)
        norm_valid |-> (norm_yaw >= 0) && (norm_yaw < `DEG_360)
    );

endmodule

`default_nettype wire
